/* dv/streamTb.sv */
//////////////////////////////////////////////////
// Directed tests on the two-unit stream top level
// Host strobes honour busy and level, as the design requires
//////////////////////////////////////////////////
`include "stream_consts.svh"

module streamTb;
	import streamPkg::*;

	localparam int units = `STREAM_UNITS;
	localparam int depth = `STREAM_BUFF_DEPTH;
	localparam int timeoutCycles = 2000;

	typedef logic [$clog2(`STREAM_BUFF_DEPTH):0] level_t;
	typedef logic [`STREAM_TAG_WIDTH-1:0] tag_t;

	logic						clock;
	logic						reset;
	logic [units-1:0]			cmdValid;
	accessCmd_t [units-1:0]		cmd;
	logic [units-1:0]			pushValid;
	data_t [units-1:0]			pushData;
	logic [units-1:0]			popValid;
	data_t [units-1:0]			popData;
	level_t [units-1:0]			level;
	logic [units-1:0]			busy;
	logic [units-1:0]			tokenValid;
	commitToken_t [units-1:0]	token;

	data_t			mirror [`STREAM_MEM_DEPTH];		// Expected memory contents
	data_t			pushed [units][$];				// Pushed, not yet claimed by a store
	data_t			expectData [units][$];			// Load words in pop order
	commitToken_t	expectTokens [units][$];		// Tokens in issue order
	int				errorCount;
	int				timeoutCount;
	logic [31:0]	lfsrState;

	streamTop i_dut (
		.clock(			clock		),
		.reset(			reset		),
		.cmdValid(		cmdValid	),
		.cmd(			cmd			),
		.pushValid(		pushValid	),
		.pushData(		pushData	),
		.popValid(		popValid	),
		.popData(		popData		),
		.level(			level		),
		.busy(			busy		),
		.tokenValid(	tokenValid	),
		.token(			token		)
	);

	always #5 clock = ~clock;

	//////////////////////////////////////////////////
	// Random data and timing helpers
	//////////////////////////////////////////////////
	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);	// Taps 32 22 2 1
	endfunction

	function automatic data_t randomWord();
		data_t word;
		for (int b = 0; b < `STREAM_DATA_WIDTH; b++) begin
			lfsrState = lfsrStep(lfsrState);
			word[b] = lfsrState[0];
		end
		return word;
	endfunction

	task automatic nextCycle();
		@(posedge clock);
		#1;							// Drive and sample after the edge
	endtask

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////
	task automatic checkData(input string name, input data_t expected, input data_t actual);
		if (actual !== expected) begin
			errorCount++;
			$display("Error at %0t: %s expected %h, actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic checkToken(input string name, input commitToken_t expected,
			input commitToken_t actual);
		if (actual !== expected) begin
			errorCount++;
			$display("Error at %0t: %s expected tag %0d op %s, actual tag %0d op %s", $time,
				name, expected.tag, expected.op.name(), actual.tag, actual.op.name());
		end
	endtask

	task automatic checkLevel(input string name, input level_t expected, input level_t actual);
		if (actual !== expected) begin
			errorCount++;
			$display("Error at %0t: %s expected %0d, actual %0d", $time, name, expected, actual);
		end
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			errorCount++;
			$display("Error at %0t: %s expected %b, actual %b", $time, name, expected, actual);
		end
	endtask

	// Token order and level bound, checked mid-cycle
	always @(negedge clock) begin
		if (!reset) begin
			for (int u = 0; u < units; u++) begin
				if (level[u] > level_t'(depth)) begin
					errorCount++;
					$display("Unit %0d level %0d is above the buffer depth at %0t",
						u, level[u], $time);
				end
				if (tokenValid[u] && expectTokens[u].size() == 0) begin
					errorCount++;
					$display("Unit %0d raised a commit token at %0t with no command pending",
						u, $time);
				end else if (tokenValid[u]) begin
					checkToken($sformatf("token[%0d]", u), expectTokens[u].pop_front(), token[u]);
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Drive tasks
	//////////////////////////////////////////////////
	task automatic sendCommand(input int unit, input accessOp_e opcode, input address_t baseAddr,
			input address_t step, input address_t count, input tag_t tag);
		accessCmd_t command;
		commitToken_t expected;
		address_t addr;
		int waited;
		command.op		= opcode;
		command.base	= baseAddr;
		command.stride	= step;
		command.length	= count;
		command.tag		= tag;
		expected.tag	= tag;
		expected.op		= opcode;
		waited = 0;
		nextCycle();
		while (busy[unit] && waited < timeoutCycles) begin
			nextCycle();
			waited++;
		end
		if (busy[unit]) begin
			timeoutCount++;
			$display("Timeout at %0t: unit %0d stayed busy, command tag %0d never sent",
				$time, unit, tag);
			return;
		end
		cmd[unit] = command;
		cmdValid[unit] = 1'b1;
		expectTokens[unit].push_back(expected);
		addr = baseAddr;
		for (int i = 0; i < int'(count); i++) begin
			if (opcode == opLoad) begin
				expectData[unit].push_back(mirror[addr]);
			end else if (pushed[unit].size() == 0) begin
				errorCount++;
				$display("Store tag %0d on unit %0d is longer than the pushed data", tag, unit);
			end else begin
				mirror[addr] = pushed[unit].pop_front();	// Later words overwrite
			end
			addr = addr + step;							// Wraps modulo 256
		end
		nextCycle();
		cmdValid[unit] = 1'b0;
	endtask

	task automatic pushWords(input int unit, input int count);
		data_t word;
		int waited;
		for (int i = 0; i < count; i++) begin
			nextCycle();
			pushValid[unit] = 1'b0;
			waited = 0;
			while (level[unit] >= level_t'(depth) && waited < timeoutCycles) begin
				nextCycle();
				waited++;
			end
			if (level[unit] >= level_t'(depth)) begin
				timeoutCount++;
				$display("Timeout at %0t: unit %0d buffer never had room for a push",
					$time, unit);
				return;
			end
			word = randomWord();
			pushData[unit] = word;
			pushValid[unit] = 1'b1;
			pushed[unit].push_back(word);
		end
		nextCycle();
		pushValid[unit] = 1'b0;
	endtask

	task automatic popWords(input int unit, input int count);
		int waited;
		for (int i = 0; i < count; i++) begin
			nextCycle();
			popValid[unit] = 1'b0;
			waited = 0;
			while (level[unit] == '0 && waited < timeoutCycles) begin
				nextCycle();
				waited++;
			end
			if (level[unit] == '0) begin
				timeoutCount++;
				$display("Timeout at %0t: unit %0d buffer stayed empty, %0d pops left",
					$time, unit, count - i);
				return;
			end
			if (expectData[unit].size() == 0) begin
				errorCount++;
				$display("Unit %0d holds data at %0t that no load accounts for", unit, $time);
			end else begin
				checkData($sformatf("popData[%0d]", unit), expectData[unit].pop_front(),
					popData[unit]);
			end
			popValid[unit] = 1'b1;
		end
		nextCycle();
		popValid[unit] = 1'b0;
	endtask

	task automatic waitToken(input int unit);
		int waited;
		waited = 0;
		while (expectTokens[unit].size() != 0 && waited < timeoutCycles) begin
			nextCycle();
			waited++;
		end
		if (expectTokens[unit].size() != 0) begin
			timeoutCount++;
			$display("Timeout at %0t: unit %0d still owes %0d commit tokens",
				$time, unit, expectTokens[unit].size());
		end
	endtask

	task automatic storeThenLoad(input int unit, input address_t baseAddr, input address_t step,
			input address_t count, input tag_t tag);
		pushWords(unit, int'(count));
		sendCommand(unit, opStore, baseAddr, step, count, tag);
		waitToken(unit);
		sendCommand(unit, opLoad, baseAddr, step, count, tag + 4'd1);
		popWords(unit, int'(count));
		waitToken(unit);
		checkLevel($sformatf("level[%0d]", unit), '0, level[unit]);
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////
	task automatic roundTripTest();
		storeThenLoad(0, 8'd16, 8'd3, 8'd8, 4'd2);
	endtask

	task automatic tokenOrderTest();
		pushWords(1, 2);
		sendCommand(1, opStore, 8'd60, 8'd1, 8'd2, 4'd3);		// Three queued back to back
		sendCommand(1, opLoad, 8'd60, 8'd1, 8'd2, 4'd4);
		sendCommand(1, opStore, 8'd60, 8'd1, 8'd0, 4'd5);
		waitToken(1);
		popWords(1, 2);
		checkLevel("level[1]", '0, level[1]);
	endtask

	task automatic concurrentUnitsTest();
		fork
			storeThenLoad(0, 8'd40, 8'd2, 8'd10, 4'd6);
			storeThenLoad(1, 8'd64, 8'd5, 8'd10, 4'd6);
		join
	endtask

	task automatic strideWrapTest();
		pushWords(1, 5);
		sendCommand(1, opStore, 8'd200, 8'd0, 8'd5, 4'd8);		// Last word lands at base
		sendCommand(1, opLoad, 8'd200, 8'd0, 8'd3, 4'd9);
		waitToken(1);
		popWords(1, 3);
		storeThenLoad(1, 8'd250, 8'd3, 8'd4, 4'd10);			// 250 253 0 3
	endtask

	task automatic limitsTest();
		pushWords(0, 16);
		sendCommand(0, opStore, 8'd128, 8'd1, 8'd16, 4'd1);
		waitToken(0);
		for (int k = 0; k < 4; k++) begin
			sendCommand(0, opLoad, address_t'(128 + 4 * k), 8'd1, 8'd4, tag_t'(2 + k));
		end
		waitToken(0);
		checkLevel("level[0]", level_t'(depth), level[0]);
		sendCommand(0, opLoad, 8'd0, 8'd0, 8'd0, 4'd6);		// Empty command
		waitToken(0);
		checkLevel("level[0]", level_t'(depth), level[0]);
		// Buffer full, so the first load stalls and the rest fill the queue
		for (int k = 0; k < 4; k++) begin
			sendCommand(0, opLoad, address_t'(128 + 4 * k), 8'd1, 8'd4, tag_t'(7 + k));
		end
		sendCommand(0, opLoad, 8'd128, 8'd1, 8'd16, 4'd11);
		checkBit("busy[0]", 1'b1, busy[0]);
		popWords(0, 31);
		if (expectTokens[0].size() == 0) begin
			errorCount++;
			$display("16-word load on unit 0 finished before the buffer could hold it");
		end
		popWords(0, 17);
		waitToken(0);
		checkLevel("level[0]", '0, level[0]);
		checkBit("busy[0]", 1'b0, busy[0]);
	endtask

	initial begin
		clock		= 1'b0;
		reset		= 1'b1;
		cmdValid	= '0;
		cmd			= '0;
		pushValid	= '0;
		pushData	= '0;
		popValid	= '0;
		lfsrState	= 32'hea72e5b7;
		errorCount	= 0;
		timeoutCount = 0;
		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;
		for (int u = 0; u < units; u++) begin
			checkBit($sformatf("busy[%0d]", u), 1'b0, busy[u]);
			checkBit($sformatf("tokenValid[%0d]", u), 1'b0, tokenValid[u]);
			checkLevel($sformatf("level[%0d]", u), '0, level[u]);
		end

		roundTripTest();
		tokenOrderTest();
		concurrentUnitsTest();
		strideWrapTest();
		limitsTest();
		repeat (20) nextCycle();					// Catch stray tokens

		$display("Errors %0d, timeouts %0d", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* filelist.f */
+incdir+include
hdl/streamPkg.sv
hdl/ringBuffer.sv
hdl/accessSequencer.sv
hdl/loadStoreUnit.sv
hdl/memoryArbiter.sv
hdl/dataMemory.sv
hdl/streamTop.sv
dv/streamTb.sv

/* hdl/accessSequencer.sv */
//////////////////////////////////////////////////
// Commands run strictly in order, one word per grant
// Addresses wrap modulo the memory depth
//////////////////////////////////////////////////
`include "stream_consts.svh"

module accessSequencer (
	input	logic							clock,
	input	logic							reset,
	input	logic							cmdValid,
	input	streamPkg::accessCmd_t			cmd,
	input	logic							memGrant,
	input	logic							readValid,
	input	logic							bufferEmpty,
	input	logic [$clog2(`STREAM_BUFF_DEPTH):0]	bufferLevel,
	input	streamPkg::data_t				storeData,		// Buffer head
	output	logic							busy,			// Queue full
	output	logic							memRequest,
	output	streamPkg::memReq_t				memReq,
	output	logic							storePop,
	output	logic							tokenValid,
	output	streamPkg::commitToken_t		token
);
	import streamPkg::*;

	localparam int queueBits = $clog2(`STREAM_QUEUE_DEPTH);
	localparam int levelBits = $clog2(`STREAM_BUFF_DEPTH) + 1;

	//////////////////////////////////////////////////
	// Command queue
	//////////////////////////////////////////////////
	accessCmd_t				cmdQueue [`STREAM_QUEUE_DEPTH];
	logic [queueBits-1:0]	queueWrPtr;
	logic [queueBits-1:0]	queueRdPtr;
	logic [queueBits:0]		queueCount;
	logic					queuePush;
	logic					queuePop;

	seqState_e				state;
	accessCmd_t				current;		// Running command
	address_t				elemIndex;
	address_t				elemAddr;
	address_t				lastIndex;
	logic [levelBits-1:0]	outstanding;	// Reads granted, data not back
	logic [levelBits:0]		reserved;
	logic					isLoad;
	logic					hasRoom;
	logic					allIssued;
	logic					granted;
	logic					lastGrant;
	logic					lastRead;

	assign busy			= queueCount == (queueBits+1)'(`STREAM_QUEUE_DEPTH);
	assign queuePush	= cmdValid & ~busy;
	assign queuePop		= (state != seqRun) & (queueCount != '0);	// Idle or commit

	always_ff @(posedge clock) begin
		if (queuePush) begin
			cmdQueue[queueWrPtr] <= cmd;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			queueWrPtr	<= '0;
			queueRdPtr	<= '0;
			queueCount	<= '0;
		end else begin
			if (queuePush) begin
				queueWrPtr <= queueWrPtr + 1'b1;
			end
			if (queuePop) begin
				queueRdPtr <= queueRdPtr + 1'b1;
			end
			case ({queuePush, queuePop})
				2'b10:		queueCount <= queueCount + 1'b1;
				2'b01:		queueCount <= queueCount - 1'b1;
				default:	queueCount <= queueCount;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Strided request generation
	//////////////////////////////////////////////////
	assign isLoad		= current.op == opLoad;
	assign lastIndex	= current.length - address_t'(1);
	assign allIssued	= elemIndex == current.length;
	assign reserved		= {1'b0, bufferLevel} + {1'b0, outstanding};
	assign hasRoom		= reserved < (levelBits+1)'(`STREAM_BUFF_DEPTH);

	assign memRequest	= (state == seqRun) & ~allIssued & (isLoad ? hasRoom : ~bufferEmpty);
	assign granted		= memRequest & memGrant;
	assign lastGrant	= granted & (elemIndex == lastIndex);
	assign lastRead		= allIssued & readValid & (outstanding == levelBits'(1));
	assign storePop		= granted & ~isLoad;		// Word leaves with the grant

	assign memReq		= '{write: ~isLoad, address: elemAddr, writeData: storeData};
	assign tokenValid	= state == seqCommit;
	assign token		= '{tag: current.tag, op: current.op};

	always_ff @(posedge clock) begin
		if (queuePop) begin
			current		<= cmdQueue[queueRdPtr];
			elemIndex	<= '0;
			elemAddr	<= cmdQueue[queueRdPtr].base;
		end else if (granted) begin
			elemIndex	<= elemIndex + 1'b1;
			elemAddr	<= elemAddr + current.stride;		// Wraps modulo 256
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			outstanding <= '0;
		end else begin
			case ({granted & isLoad, readValid})
				2'b10:		outstanding <= outstanding + 1'b1;
				2'b01:		outstanding <= outstanding - 1'b1;
				default:	outstanding <= outstanding;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= seqIdle;
		end else begin
			case (state)
				seqIdle, seqCommit: begin
					if (queuePop) begin
						state <= (cmdQueue[queueRdPtr].length == '0) ? seqCommit : seqRun;
					end else begin
						state <= seqIdle;
					end
				end
				seqRun: begin
					if (isLoad ? lastRead : lastGrant) begin
						state <= seqCommit;
					end
				end
				default: state <= seqIdle;
			endcase
		end
	end

endmodule

/* hdl/dataMemory.sv */
//////////////////////////////////////////////////
// No reset, contents undefined until written
//////////////////////////////////////////////////
`include "stream_consts.svh"

module dataMemory (
	input	logic					clock,
	input	logic					memEnable,
	input	streamPkg::memReq_t		memReq,
	output	streamPkg::data_t		readData		// Valid one cycle after read
);
	import streamPkg::*;

	data_t mem [`STREAM_MEM_DEPTH];

	//////////////////////////////////////////////////
	// Single port, write or read per cycle
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (memEnable) begin
			if (memReq.write) begin
				mem[memReq.address] <= memReq.writeData;
			end else begin
				readData <= mem[memReq.address];
			end
		end
	end

endmodule

/* hdl/loadStoreUnit.sv */
//////////////////////////////////////////////////
// Host must honour busy and level
// Overflowing pushes and underflowing pops are dropped
//////////////////////////////////////////////////
`include "stream_consts.svh"

module loadStoreUnit (
	input	logic							clock,
	input	logic							reset,
	input	logic							cmdValid,
	input	streamPkg::accessCmd_t			cmd,
	input	logic							pushValid,
	input	streamPkg::data_t				pushData,
	input	logic							popValid,
	output	streamPkg::data_t				popData,		// Head, same cycle as pop
	output	logic [$clog2(`STREAM_BUFF_DEPTH):0]	level,
	output	logic							busy,
	output	logic							tokenValid,
	output	streamPkg::commitToken_t		token,
	output	logic							memRequest,
	output	streamPkg::memReq_t				memReq,
	input	logic							memGrant,
	input	logic							readValid,
	input	streamPkg::data_t				readData
);
	import streamPkg::*;

	data_t		bufferIn;
	data_t		bufferOut;
	logic		bufferWrite;
	logic		bufferRead;
	logic		bufferFull;
	logic		bufferEmpty;
	logic		hostPush;
	logic		hostPop;
	logic		storePop;

	//////////////////////////////////////////////////
	// Buffer port sharing
	//////////////////////////////////////////////////
	// Load returns and host pushes never overlap in a correct stream,
	// so returning memory data simply wins the write port
	assign hostPush		= pushValid & ~bufferFull & ~readValid;
	assign hostPop		= popValid & ~bufferEmpty & ~storePop;	// Store pops win

	assign bufferWrite	= readValid | hostPush;
	assign bufferIn		= readValid ? readData : pushData;
	assign bufferRead	= storePop | hostPop;
	assign popData		= bufferOut;

	ringBuffer #(
		.depth(			`STREAM_BUFF_DEPTH	)
	) dataRing (
		.clock(			clock				),
		.reset(			reset				),
		.write(			bufferWrite			),
		.writeData(		bufferIn			),
		.read(			bufferRead			),
		.readData(		bufferOut			),
		.full(			bufferFull			),
		.empty(			bufferEmpty			),
		.level(			level				)
	);

	accessSequencer sequencer (
		.clock(			clock				),
		.reset(			reset				),
		.cmdValid(		cmdValid			),
		.cmd(			cmd					),
		.memGrant(		memGrant			),
		.readValid(		readValid			),
		.bufferEmpty(	bufferEmpty			),
		.bufferLevel(	level				),
		.storeData(		bufferOut			),
		.busy(			busy				),
		.memRequest(	memRequest			),
		.memReq(		memReq				),
		.storePop(		storePop			),
		.tokenValid(	tokenValid			),
		.token(			token				)
	);

endmodule

/* hdl/memoryArbiter.sv */
//////////////////////////////////////////////////
// Grant is combinational, read return is one cycle
//////////////////////////////////////////////////
`include "stream_consts.svh"

module memoryArbiter (
	input	logic								clock,
	input	logic								reset,
	input	logic [`STREAM_UNITS-1:0]			memRequest,
	input	streamPkg::memReq_t [`STREAM_UNITS-1:0]	memReq,
	output	logic [`STREAM_UNITS-1:0]			memGrant,
	output	logic								memEnable,
	output	streamPkg::memReq_t					memOut,
	input	streamPkg::data_t					readData,
	output	logic [`STREAM_UNITS-1:0]			readValid,		// One-hot, issuing unit
	output	streamPkg::data_t					readDataOut
);

	localparam int units = `STREAM_UNITS;
	localparam int indexBits = (units > 1) ? $clog2(units) : 1;

	logic [indexBits-1:0]	lastWinner;		// Lowest priority next cycle
	logic [indexBits-1:0]	winner;
	logic [indexBits-1:0]	readUnit;
	logic					readPending;

	// Search starts just after the last winner
	always_comb begin
		int candidate;
		logic found;
		memGrant	= '0;
		winner		= lastWinner;
		found		= 1'b0;
		for (int offset = 1; offset <= units; offset++) begin
			candidate = (int'(lastWinner) + offset) % units;
			if (!found && memRequest[candidate]) begin
				memGrant[candidate]	= 1'b1;
				winner				= indexBits'(candidate);
				found				= 1'b1;
			end
		end
	end

	assign memEnable	= |memRequest;
	assign memOut		= memReq[winner];
	assign readDataOut	= readData;

	always_comb begin
		readValid			= '0;
		readValid[readUnit]	= readPending;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			lastWinner	<= indexBits'(units - 1);	// Unit 0 first
			readPending	<= 1'b0;
			readUnit	<= '0;
		end else begin
			readPending <= memEnable & ~memOut.write;
			if (memEnable) begin
				lastWinner	<= winner;
				readUnit	<= winner;
			end
		end
	end

endmodule

/* hdl/ringBuffer.sv */
//////////////////////////////////////////////////
// Depth must be a power of two
// Writes when full and reads when empty are dropped
//////////////////////////////////////////////////
`include "stream_consts.svh"

module ringBuffer #(
	parameter int depth = `STREAM_BUFF_DEPTH
) (
	input	logic					clock,
	input	logic					reset,
	input	logic					write,
	input	streamPkg::data_t		writeData,
	input	logic					read,
	output	streamPkg::data_t		readData,		// Head entry, combinational
	output	logic					full,
	output	logic					empty,
	output	logic [$clog2(depth):0]	level			// Occupancy
);
	import streamPkg::*;

	localparam int ptrBits = $clog2(depth);

	data_t					store [depth];
	logic [ptrBits-1:0]		wrPtr;
	logic [ptrBits-1:0]		rdPtr;
	logic					doWrite;
	logic					doRead;

	assign full		= level == (ptrBits+1)'(depth);
	assign empty	= level == '0;
	assign doWrite	= write & ~full;
	assign doRead	= read & ~empty;

	assign readData	= store[rdPtr];

	always_ff @(posedge clock) begin
		if (doWrite) begin
			store[wrPtr] <= writeData;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wrPtr	<= '0;
			rdPtr	<= '0;
			level	<= '0;
		end else begin
			if (doWrite) begin
				wrPtr <= wrPtr + 1'b1;		// Wraps at depth
			end
			if (doRead) begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({doWrite, doRead})
				2'b10:		level <= level + 1'b1;
				2'b01:		level <= level - 1'b1;
				default:	level <= level;
			endcase
		end
	end

endmodule

/* hdl/streamPkg.sv */
//////////////////////////////////////////////////
// Address arithmetic wraps at the address width
//////////////////////////////////////////////////
`include "stream_consts.svh"

package streamPkg;

	typedef logic [`STREAM_DATA_WIDTH-1:0] data_t;
	typedef logic [`STREAM_ADDR_WIDTH-1:0] address_t;	// Also stride and length

	typedef enum logic {
		opLoad,
		opStore
	} accessOp_e;

	typedef struct packed {
		accessOp_e	op;
		address_t	base;
		address_t	stride;
		address_t	length;			// Element count, zero allowed
		logic [`STREAM_TAG_WIDTH-1:0] tag;
	} accessCmd_t;

	typedef struct packed {
		logic		write;
		address_t	address;
		data_t		writeData;
	} memReq_t;

	// Returned once per finished command
	typedef struct packed {
		logic [`STREAM_TAG_WIDTH-1:0] tag;
		accessOp_e	op;
	} commitToken_t;

	typedef enum logic [1:0] {
		seqIdle,
		seqRun,
		seqCommit
	} seqState_e;

endpackage

/* hdl/streamTop.sv */
//////////////////////////////////////////////////
// No ordering between units sharing the memory
//////////////////////////////////////////////////
`include "stream_consts.svh"

module streamTop (
	input	logic										clock,
	input	logic										reset,
	input	logic [`STREAM_UNITS-1:0]					cmdValid,
	input	streamPkg::accessCmd_t [`STREAM_UNITS-1:0]	cmd,
	input	logic [`STREAM_UNITS-1:0]					pushValid,
	input	streamPkg::data_t [`STREAM_UNITS-1:0]		pushData,
	input	logic [`STREAM_UNITS-1:0]					popValid,
	output	streamPkg::data_t [`STREAM_UNITS-1:0]		popData,
	output	logic [`STREAM_UNITS-1:0][$clog2(`STREAM_BUFF_DEPTH):0]	level,
	output	logic [`STREAM_UNITS-1:0]					busy,
	output	logic [`STREAM_UNITS-1:0]					tokenValid,
	output	streamPkg::commitToken_t [`STREAM_UNITS-1:0]	token
);
	import streamPkg::*;

	logic [`STREAM_UNITS-1:0]		memRequest;
	memReq_t [`STREAM_UNITS-1:0]	memReq;
	logic [`STREAM_UNITS-1:0]		memGrant;
	logic [`STREAM_UNITS-1:0]		readValid;
	logic							memEnable;
	memReq_t						memOut;
	data_t							memData;		// Raw memory output
	data_t							readDataOut;	// Shared return bus

	for (genvar unit = 0; unit < `STREAM_UNITS; unit++) begin : unitSlot
		loadStoreUnit lsu (
			.clock(			clock				),
			.reset(			reset				),
			.cmdValid(		cmdValid[unit]		),
			.cmd(			cmd[unit]			),
			.pushValid(		pushValid[unit]		),
			.pushData(		pushData[unit]		),
			.popValid(		popValid[unit]		),
			.popData(		popData[unit]		),
			.level(			level[unit]			),
			.busy(			busy[unit]			),
			.tokenValid(	tokenValid[unit]	),
			.token(			token[unit]			),
			.memRequest(	memRequest[unit]	),
			.memReq(		memReq[unit]		),
			.memGrant(		memGrant[unit]		),
			.readValid(		readValid[unit]		),
			.readData(		readDataOut			)
		);
	end

	memoryArbiter arbiter (
		.clock(			clock			),
		.reset(			reset			),
		.memRequest(	memRequest		),
		.memReq(		memReq			),
		.memGrant(		memGrant		),
		.memEnable(		memEnable		),
		.memOut(		memOut			),
		.readData(		memData			),
		.readValid(		readValid		),
		.readDataOut(	readDataOut		)
	);

	dataMemory memory (
		.clock(			clock			),
		.memEnable(		memEnable		),
		.memReq(		memOut			),
		.readData(		memData			)
	);

endmodule

/* include/stream_consts.svh */
//////////////////////////////////////////////////
// Word addressed, so 8 address bits cover all memory
// Buffer and queue depths must be powers of two
//////////////////////////////////////////////////
`ifndef STREAM_CONSTS_SVH
`define STREAM_CONSTS_SVH

`define STREAM_DATA_WIDTH	32		// Memory word
`define STREAM_ADDR_WIDTH	8		// Word address, stride and length
`define STREAM_MEM_DEPTH	256		// Words in data memory
`define STREAM_BUFF_DEPTH	16		// Ring buffer entries per unit
`define STREAM_QUEUE_DEPTH	4		// Command queue entries per unit
`define STREAM_UNITS		2		// Load/store units on the arbiter
`define STREAM_TAG_WIDTH	4		// Command tag

`endif

/* run.sh */
#!/bin/sh
# Verilator build and run of the stream testbench, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f --top-module streamTb -o streamSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/streamSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Regression passed"; then
	exit 0
fi
echo "Simulation did not report success"
exit 1
